// File: rtl/pgm_mem_macros.svh
`ifndef PGM_MEM_MACROS_SVH
`define PGM_MEM_MACROS_SVH

// DDR port geometry, one 64-bit beat per address
`define PGM_DDR_AW   29  // Beat address width
`define PGM_DDR_DW   64  // Beat data width
`define PGM_DDR_BEW  8   // One enable per byte of the beat

// Host download port, byte addressed, 16-bit words
`define PGM_IOCTL_AW 27
`define PGM_IOCTL_DW 16

// Download index that goes to DDR
// Other indexes are ignored by the loader
`define PGM_ROM_INDEX 0

// Main CPU is word addressed, bits 23 down to 1
`define PGM_CPU_AW   23

`endif

// File: rtl/pgm_mem_pkg.sv
`include "pgm_mem_macros.svh"

package pgm_mem_pkg;

    // One full DDR beat, four CPU words wide
    typedef logic [`PGM_DDR_DW-1:0] ddr_beat_t;

    // Word as the CPU sees it, a quarter of a beat
    typedef logic [`PGM_DDR_DW/4-1:0] cpu_word_t;

    // Beat address on the DDR port
    typedef logic [`PGM_DDR_AW-1:0] ddr_addr_t;

    // Byte enables, bit 0 is the lowest byte of the beat
    typedef logic [`PGM_DDR_BEW-1:0] ddr_be_t;

    // Arbiter states
    // Non-idle values name the client that owns the bus
    typedef enum logic [1:0] {
        arb_idle  = 2'd0,  // No grant, waiting for requests
        arb_cpu   = 2'd1,  // Main CPU, highest priority
        arb_video = 2'd2,  // Video engine
        arb_audio = 2'd3   // Sound chip, lowest priority
    } arb_state_e;

endpackage

// File: rtl/ddr_rd_if.sv
`timescale 1ns/1ps

// Level req/ack read channel between one client and the DDR arbiter
// Client holds req and addr until ack rises, then drops req
// Arbiter holds ack and data until it sees req low
interface ddr_rd_if #(
    parameter type payload_t = pgm_mem_pkg::ddr_beat_t
);

    logic                  req;   // Read request, level
    pgm_mem_pkg::ddr_addr_t addr; // Beat address, stable while req high
    logic                  ack;   // Data valid, held until req drops
    payload_t              data;  // Returned beat or sample

    // Requesting side
    modport client (
        output req,
        output addr,
        input  ack,
        input  data
    );

    // Serving side
    modport arbiter (
        input  req,
        input  addr,
        output ack,
        output data
    );

endinterface

// File: rtl/ldr_write_latch.sv
`timescale 1ns/1ps
`include "pgm_mem_macros.svh"

module ldr_write_latch (
    input  logic                       fixed_50m_clk,
    input  logic                       reset,
    input  logic                       ioctl_download,  // Download window from host
    input  logic                       ioctl_wr,        // One word strobe
    input  logic [`PGM_IOCTL_AW-1:0]   ioctl_addr,      // Byte address of the word
    input  logic [`PGM_IOCTL_DW-1:0]   ioctl_dout,
    input  logic [7:0]                 ioctl_index,
    input  logic                       ddram_busy,
    output logic                       wr_pending,      // Write on the bus, also host wait
    output pgm_mem_pkg::ddr_addr_t     wr_addr,
    output pgm_mem_pkg::ddr_beat_t     wr_data,
    output pgm_mem_pkg::ddr_be_t       wr_be
);

    // Zero padding between host beat index and DDR beat address
    localparam int PAD_W = `PGM_DDR_AW - (`PGM_IOCTL_AW - 3);

    logic                    rom_hit;  // Host write aimed at DDR
    logic                    wr_take;  // Capture this word now
    pgm_mem_pkg::ddr_be_t    be_next;

    assign rom_hit = ioctl_index == 8'(`PGM_ROM_INDEX);
    assign wr_take = ioctl_download && ioctl_wr && rom_hit && !wr_pending;

    // Pair 0 is bytes 1:0, pair 3 is bytes 7:6
    assign be_next = pgm_mem_pkg::ddr_be_t'(2'b11) << {ioctl_addr[2:1], 1'b0};

    // Pending flag, one write in flight at a time
    always_ff @(posedge fixed_50m_clk) begin
        if (reset || !ioctl_download) begin
            wr_pending <= 1'b0;  // Leaving the download drops any leftover
        end else if (wr_take) begin
            wr_pending <= 1'b1;
        end else if (wr_pending && !ddram_busy) begin
            wr_pending <= 1'b0;  // Bus took it this cycle
        end
    end

    // Payload only moves on capture, stays put while waiting for the bus
    always_ff @(posedge fixed_50m_clk) begin
        if (wr_take) begin
            wr_addr <= {{PAD_W{1'b0}}, ioctl_addr[`PGM_IOCTL_AW-1:3]};
            wr_data <= {4{ioctl_dout}};  // Same word in every lane, be picks one
            wr_be   <= be_next;
        end
    end

endmodule

// File: rtl/ddr_rd_arbiter.sv
`timescale 1ns/1ps

module ddr_rd_arbiter (
    input  logic                   fixed_50m_clk,
    input  logic                   reset,
    input  logic                   download,          // Loader owns the bus
    input  logic                   ddram_busy,
    input  logic                   ddram_dout_ready,  // Read data strobe
    input  pgm_mem_pkg::ddr_beat_t ddram_dout,
    ddr_rd_if.arbiter              cpu,               // Highest priority
    ddr_rd_if.arbiter              vid,
    ddr_rd_if.arbiter              snd,               // Lowest priority
    output logic                   rd_pulse,          // One cycle per grant
    output pgm_mem_pkg::ddr_addr_t rd_addr
);

    pgm_mem_pkg::arb_state_e state_q;
    pgm_mem_pkg::arb_state_e grant_next;
    logic                    issued_q;   // Read already sent for this grant
    logic [2:0]              req_v;      // Requests, bit 0 is CPU
    logic [2:0]              ack_q;      // Held acknowledges, same order
    logic [1:0]              slot;       // Client index of the current grant
    logic                    granted;
    logic                    done;       // Read data arrives this cycle

    // Per-client beat buffers, payload only
    pgm_mem_pkg::ddr_beat_t  beat_q [3];

    assign req_v = {snd.req, vid.req, cpu.req};

    // Fixed priority, a client is skipped while its ack is still up
    always_comb begin
        grant_next = pgm_mem_pkg::arb_idle;
        if (req_v[0] && !ack_q[0]) begin
            grant_next = pgm_mem_pkg::arb_cpu;
        end else if (req_v[1] && !ack_q[1]) begin
            grant_next = pgm_mem_pkg::arb_video;
        end else if (req_v[2] && !ack_q[2]) begin
            grant_next = pgm_mem_pkg::arb_audio;
        end
    end

    // Owner of the bus and the address it reads
    always_comb begin
        unique case (state_q)
            pgm_mem_pkg::arb_cpu: begin
                slot    = 2'd0;
                rd_addr = cpu.addr;
            end
            pgm_mem_pkg::arb_video: begin
                slot    = 2'd1;
                rd_addr = vid.addr;
            end
            pgm_mem_pkg::arb_audio: begin
                slot    = 2'd2;
                rd_addr = snd.addr;
            end
            default: begin
                slot    = 2'd0;  // Idle, nothing driven on the bus
                rd_addr = '0;
            end
        endcase
    end

    assign granted = state_q != pgm_mem_pkg::arb_idle;

    // Combinational pulse, first non-busy cycle of the grant only
    assign rd_pulse = granted && !issued_q && !ddram_busy;

    // Only a strobe after our own read counts as completion
    assign done = granted && issued_q && ddram_dout_ready && !download;

    // State and issued flag
    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            state_q  <= pgm_mem_pkg::arb_idle;
            issued_q <= 1'b0;
        end else if (download) begin
            state_q  <= pgm_mem_pkg::arb_idle;  // Loader has the port
            issued_q <= 1'b0;
        end else if (!granted) begin
            issued_q <= 1'b0;
            state_q  <= grant_next;             // Stays idle when nobody asks
        end else begin
            if (rd_pulse) begin
                issued_q <= 1'b1;
            end
            if (done) begin
                state_q <= pgm_mem_pkg::arb_idle;
            end
        end
    end

    // Ack rises with the data, falls once idle sees the request gone
    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            ack_q <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (done && slot == 2'(i)) begin
                    ack_q[i] <= 1'b1;
                end else if (!granted && !req_v[i]) begin
                    ack_q[i] <= 1'b0;
                end
            end
        end
    end

    // Beat goes to the owning client's buffer
    always_ff @(posedge fixed_50m_clk) begin
        if (done) begin
            beat_q[slot] <= ddram_dout;
        end
    end

    // Return side of each channel
    assign cpu.ack  = ack_q[0];
    assign cpu.data = beat_q[0];  // Word select is done by the CPU side
    assign vid.ack  = ack_q[1];
    assign vid.data = beat_q[1];
    assign snd.ack  = ack_q[2];
    assign snd.data = beat_q[2];

endmodule

// File: rtl/pgm_mem_top.sv
`timescale 1ns/1ps
`include "pgm_mem_macros.svh"

module pgm_mem_top (
    input  logic                       fixed_50m_clk,
    input  logic                       reset,

    // Host download port
    input  logic                       ioctl_download,
    input  logic                       ioctl_wr,
    input  logic [`PGM_IOCTL_AW-1:0]   ioctl_addr,
    input  logic [`PGM_IOCTL_DW-1:0]   ioctl_dout,
    input  logic [7:0]                 ioctl_index,
    output logic                       ioctl_wait,

    // Main CPU, word addressed
    input  logic                       cpu_req,
    input  logic [`PGM_CPU_AW:1]       cpu_addr,
    output logic                       cpu_ack,
    output pgm_mem_pkg::cpu_word_t     cpu_data,  // Big-endian word

    // Video engine
    input  logic                       vid_req,
    input  pgm_mem_pkg::ddr_addr_t     vid_addr,
    output logic                       vid_ack,
    output pgm_mem_pkg::ddr_beat_t     vid_data,

    // Sound chip
    input  logic                       snd_req,
    input  pgm_mem_pkg::ddr_addr_t     snd_addr,
    output logic                       snd_ack,
    output pgm_mem_pkg::ddr_beat_t     snd_data,

    // DDR port
    output logic                       ddram_rd,
    output logic                       ddram_we,
    output pgm_mem_pkg::ddr_addr_t     ddram_addr,
    output pgm_mem_pkg::ddr_beat_t     ddram_din,
    output pgm_mem_pkg::ddr_be_t       ddram_be,
    input  pgm_mem_pkg::ddr_beat_t     ddram_dout,
    input  logic                       ddram_busy,
    input  logic                       ddram_dout_ready
);

    // Padding from the CPU beat index up to a DDR beat address
    localparam int CPU_PAD_W = `PGM_DDR_AW - (`PGM_CPU_AW - 2);

    logic                   wr_pending;
    pgm_mem_pkg::ddr_addr_t wr_addr;
    pgm_mem_pkg::ddr_beat_t wr_data;
    pgm_mem_pkg::ddr_be_t   wr_be;
    logic                   rd_pulse;
    pgm_mem_pkg::ddr_addr_t rd_addr;
    pgm_mem_pkg::cpu_word_t cpu_word;  // Word as stored, little-endian

    ddr_rd_if #(.payload_t(pgm_mem_pkg::ddr_beat_t)) cpu_rd ();
    ddr_rd_if #(.payload_t(pgm_mem_pkg::ddr_beat_t)) vid_rd ();
    ddr_rd_if #(.payload_t(pgm_mem_pkg::ddr_beat_t)) snd_rd ();

    // Client side of the channels
    assign cpu_rd.req  = cpu_req;
    assign cpu_rd.addr = {{CPU_PAD_W{1'b0}}, cpu_addr[`PGM_CPU_AW:3]};  // Four words per beat
    assign vid_rd.req  = vid_req;
    assign vid_rd.addr = vid_addr;
    assign snd_rd.req  = snd_req;
    assign snd_rd.addr = snd_addr;

    assign cpu_ack  = cpu_rd.ack;
    assign vid_ack  = vid_rd.ack;
    assign vid_data = vid_rd.data;
    assign snd_ack  = snd_rd.ack;
    assign snd_data = snd_rd.data;

    // Word picked by address bits 2:1, then swapped for the 68k bus
    assign cpu_word = cpu_rd.data[{cpu_addr[2:1], 4'b0000} +: `PGM_DDR_DW/4];
    assign cpu_data = {cpu_word[7:0], cpu_word[15:8]};

    ldr_write_latch u_ldr (
        .fixed_50m_clk  (fixed_50m_clk),
        .reset          (reset),
        .ioctl_download (ioctl_download),
        .ioctl_wr       (ioctl_wr),
        .ioctl_addr     (ioctl_addr),
        .ioctl_dout     (ioctl_dout),
        .ioctl_index    (ioctl_index),
        .ddram_busy     (ddram_busy),
        .wr_pending     (wr_pending),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .wr_be          (wr_be)
    );

    ddr_rd_arbiter u_arb (
        .fixed_50m_clk    (fixed_50m_clk),
        .reset            (reset),
        .download         (ioctl_download),
        .ddram_busy       (ddram_busy),
        .ddram_dout_ready (ddram_dout_ready),
        .ddram_dout       (ddram_dout),
        .cpu              (cpu_rd.arbiter),
        .vid              (vid_rd.arbiter),
        .snd              (snd_rd.arbiter),
        .rd_pulse         (rd_pulse),
        .rd_addr          (rd_addr)
    );

    // Physical port, loader during a download, arbiter otherwise
    assign ddram_addr = ioctl_download ? wr_addr : rd_addr;
    assign ddram_rd   = rd_pulse && !ioctl_download;  // Covers the cycle before idle
    assign ddram_we   = wr_pending;
    assign ddram_be   = wr_pending ? wr_be : '1;      // Reads take the full beat
    assign ddram_din  = wr_data;
    assign ioctl_wait = wr_pending;                   // Host stalls until the bus takes it

endmodule

// File: sim/ddr_model.sv
`timescale 1ns/1ps

// Behavioral DDR port, sparse beats, unwritten beats read a fill pattern
module ddr_model (
    input  logic                   fixed_50m_clk,
    input  logic                   ddram_rd,
    input  logic                   ddram_we,
    input  pgm_mem_pkg::ddr_addr_t ddram_addr,
    input  pgm_mem_pkg::ddr_beat_t ddram_din,
    input  pgm_mem_pkg::ddr_be_t   ddram_be,
    output pgm_mem_pkg::ddr_beat_t ddram_dout,
    output logic                   ddram_busy,
    output logic                   ddram_dout_ready
);

    pgm_mem_pkg::ddr_beat_t mem [pgm_mem_pkg::ddr_addr_t];  // Written beats only
    logic [31:0]            lfsr_q    = 32'hbfb8;
    logic                   busy_q    = 1'b0;
    logic                   ready_q   = 1'b0;
    pgm_mem_pkg::ddr_beat_t dout_q    = '0;
    logic                   rd_open   = 1'b0;  // One read in flight
    pgm_mem_pkg::ddr_addr_t rd_addr_q = '0;
    logic [2:0]             lat_q     = '0;    // Cycles left before data

    assign ddram_busy       = busy_q;
    assign ddram_dout       = dout_q;
    assign ddram_dout_ready = ready_q;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic pgm_mem_pkg::ddr_beat_t stored_beat(input pgm_mem_pkg::ddr_addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {3'b101, a, 3'b010, ~a};  // Whole address in both halves
    endfunction

    always @(posedge fixed_50m_clk) begin : port_side
        pgm_mem_pkg::ddr_beat_t b;
        ready_q <= 1'b0;  // Strobe lasts one cycle
        if (ddram_we && !busy_q) begin
            b = stored_beat(ddram_addr);
            for (int i = 0; i < 8; i++) begin
                if (ddram_be[i]) begin
                    b[i*8 +: 8] = ddram_din[i*8 +: 8];  // Only enabled bytes change
                end
            end
            mem[ddram_addr] = b;
        end
        if (ddram_rd && !busy_q) begin
            rd_open   <= 1'b1;
            rd_addr_q <= ddram_addr;
            lat_q     <= 3'(take_bits(3));  // 1 to 8 cycles to data
        end else if (rd_open) begin
            if (lat_q == 3'd0) begin
                dout_q  <= stored_beat(rd_addr_q);
                ready_q <= 1'b1;
                rd_open <= 1'b0;
            end else begin
                lat_q <= lat_q - 3'd1;
            end
        end
        busy_q <= take_bits(2) == 32'd0;  // Busy about one cycle in four
    end

endmodule

// File: sim/tb_pgm_mem_top.sv
`timescale 1ns/1ps
`include "pgm_mem_macros.svh"

module tb_pgm_mem_top;

    localparam int ACK_TIMEOUT  = 200;  // Covers busy stalls and the worst read latency
    localparam int DROP_TIMEOUT = 20;
    localparam int WAIT_TIMEOUT = 50;

    logic                          fixed_50m_clk = 1'b0;
    logic                          reset;
    logic                          ioctl_download;
    logic                          ioctl_wr;
    logic [`PGM_IOCTL_AW-1:0]      ioctl_addr;
    logic [`PGM_IOCTL_DW-1:0]      ioctl_dout;
    logic [7:0]                    ioctl_index;
    logic                          ioctl_wait;
    logic                          cpu_req;
    logic [`PGM_CPU_AW:1]          cpu_addr;
    logic                          cpu_ack;
    pgm_mem_pkg::cpu_word_t        cpu_data;
    logic                          vid_req;
    pgm_mem_pkg::ddr_addr_t        vid_addr;
    logic                          vid_ack;
    pgm_mem_pkg::ddr_beat_t        vid_data;
    logic                          snd_req;
    pgm_mem_pkg::ddr_addr_t        snd_addr;
    logic                          snd_ack;
    pgm_mem_pkg::ddr_beat_t        snd_data;
    logic                          ddram_rd;
    logic                          ddram_we;
    pgm_mem_pkg::ddr_addr_t        ddram_addr;
    pgm_mem_pkg::ddr_beat_t        ddram_din;
    pgm_mem_pkg::ddr_be_t          ddram_be;
    pgm_mem_pkg::ddr_beat_t        ddram_dout;
    logic                          ddram_busy;
    logic                          ddram_dout_ready;

    pgm_mem_pkg::ddr_beat_t shadow [pgm_mem_pkg::ddr_addr_t];  // Beats the loader wrote
    logic [63:0]            exp_beat [3];        // One outstanding read per client
    logic [2:0]             exp_valid = 3'b000;
    logic [63:0]            got [3];
    logic [2:0]             ack_prev = 3'b000;
    int                     ack_order [$];       // Client ids in order of ack rise
    logic                   rd_prev = 1'b0;
    logic                   wr_pend_exp = 1'b0;  // Host write not yet taken by the bus
    logic [31:0]            lfsr_q = 32'hbfb8;
    int                     err_value = 0;
    int                     err_proto = 0;
    int                     err_timeout = 0;

    always #10 fixed_50m_clk = ~fixed_50m_clk;  // 50 MHz

    pgm_mem_top u_dut (.*);

    ddr_model u_ddr (
        .fixed_50m_clk    (fixed_50m_clk),
        .ddram_rd         (ddram_rd),
        .ddram_we         (ddram_we),
        .ddram_addr       (ddram_addr),
        .ddram_din        (ddram_din),
        .ddram_be         (ddram_be),
        .ddram_dout       (ddram_dout),
        .ddram_busy       (ddram_busy),
        .ddram_dout_ready (ddram_dout_ready)
    );

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    // Reference beat with loader data over the fill pattern
    function automatic pgm_mem_pkg::ddr_beat_t ref_beat(input pgm_mem_pkg::ddr_addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return {3'b101, a, 3'b010, ~a};
    endfunction

    // Word of lane 0..3 counted from the low end with bytes swapped for the CPU
    function automatic pgm_mem_pkg::cpu_word_t ref_cpu_word(input pgm_mem_pkg::ddr_addr_t a,
                                                            input int lane);
        pgm_mem_pkg::ddr_beat_t b;
        logic [15:0]            w;
        b = ref_beat(a);
        w = b[lane*16 +: 16];
        return {w[7:0], w[15:8]};
    endfunction

    function automatic logic ack_of(input int client);
        case (client)
            0:       return cpu_ack;
            1:       return vid_ack;
            default: return snd_ack;
        endcase
    endfunction

    task automatic tick();
        @(posedge fixed_50m_clk);
        #1;  // Inputs change just after the edge
    endtask

    task automatic end_run();
        $display("errors: %0d value, %0d protocol, %0d timeout",
                 err_value, err_proto, err_timeout);
        if (err_value + err_proto + err_timeout == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        err_timeout++;
        $display("timed out at %0t waiting for %s", $time, what);
        end_run();
    endtask

    // Host word lands in its lane of the beat and other bytes stay
    task automatic shadow_write(input logic [26:0] haddr, input logic [15:0] w);
        pgm_mem_pkg::ddr_beat_t b;
        pgm_mem_pkg::ddr_addr_t a;
        int                     lane;
        a    = {5'd0, haddr[26:3]};
        lane = haddr[2:1];
        b    = ref_beat(a);
        b[lane*16 +: 16] = w;
        shadow[a] = b;
    endtask

    task automatic host_write(input logic [26:0] haddr, input logic [15:0] w,
                              input logic [7:0] index);
        int n;
        ioctl_addr  = haddr;
        ioctl_dout  = w;
        ioctl_index = index;
        ioctl_wr    = 1'b1;
        tick();
        ioctl_wr = 1'b0;
        if (index != 8'd0) begin
            if (ioctl_wait) begin  // Other indexes never reach DDR
                err_value++;
                $display("[FAIL] %0t write with index %0d was latched", $time, index);
            end
        end else begin
            if (!ioctl_wait) begin
                err_value++;
                $display("[FAIL] %0t ioctl_wait low after a ROM write", $time);
            end
            shadow_write(haddr, w);
            n = 0;
            while (ioctl_wait) begin
                tick();
                n++;
                if (n > WAIT_TIMEOUT) begin
                    timed_out("ioctl_wait to clear");
                end
            end
        end
    endtask

    task automatic set_req(input int client, input logic v);
        case (client)
            0:       cpu_req = v;
            1:       vid_req = v;
            default: snd_req = v;
        endcase
    endtask

    task automatic start_read(input int client, input pgm_mem_pkg::ddr_addr_t beat,
                              input logic [1:0] lane);
        pgm_mem_pkg::ddr_addr_t a;
        a = client == 0 ? {8'd0, beat[20:0]} : beat;  // CPU reaches 21 beat bits
        case (client)
            0: begin
                cpu_addr       = {a[20:0], lane};
                exp_beat[0]    = {48'd0, ref_cpu_word(a, lane)};
            end
            1: begin
                vid_addr       = a;
                exp_beat[1]    = ref_beat(a);
            end
            default: begin
                snd_addr       = a;
                exp_beat[2]    = ref_beat(a);
            end
        endcase
        exp_valid[client] = 1'b1;
        set_req(client, 1'b1);
    endtask

    task automatic finish_read(input int client);
        int n;
        int hold;
        n = 0;
        while (!ack_of(client)) begin
            tick();
            n++;
            if (n > ACK_TIMEOUT) begin
                timed_out("a read acknowledge");
            end
        end
        hold = rand_bits(2);  // Keep req up a few extra cycles
        repeat (hold) begin
            tick();
            if (!ack_of(client)) begin
                err_value++;
                $display("[FAIL] %0t client %0d ack fell with req still high", $time, client);
            end
        end
        set_req(client, 1'b0);
        n = 0;
        while (ack_of(client)) begin
            tick();
            n++;
            if (n > DROP_TIMEOUT) begin
                timed_out("an ack to fall after its req");
            end
        end
    endtask

    task automatic do_read(input int client, input pgm_mem_pkg::ddr_addr_t beat,
                           input logic [1:0] lane);
        start_read(client, beat, lane);
        finish_read(client);
    endtask

    // Bus rules checked on every edge
    always @(posedge fixed_50m_clk) begin
        if (reset) begin
            wr_pend_exp = 1'b0;
        end else begin
            if (ddram_rd && ddram_busy) begin
                err_proto++;
                $display("read pulse issued while the bus was busy at %0t", $time);
            end
            if (ddram_rd && rd_prev) begin
                err_proto++;
                $display("read pulse longer than one cycle at %0t", $time);
            end
            if (ddram_rd && ioctl_download) begin
                err_proto++;
                $display("read pulse during a download at %0t", $time);
            end
            if (ddram_rd && ddram_be !== 8'hff) begin
                err_value++;
                $display("[FAIL] %0t read with byte enables %h", $time, ddram_be);
            end
            if (ioctl_wait !== wr_pend_exp) begin
                err_value++;
                $display("[FAIL] %0t ioctl_wait %b, expected %b", $time, ioctl_wait, wr_pend_exp);
            end
            if (ddram_we !== wr_pend_exp) begin
                err_value++;
                $display("[FAIL] %0t ddram_we %b, expected %b", $time, ddram_we, wr_pend_exp);
            end
            rd_prev = ddram_rd;
            // Pending write after this edge, one at a time until the bus is free
            if (!ioctl_download) begin
                wr_pend_exp = 1'b0;
            end else if (!wr_pend_exp) begin
                wr_pend_exp = ioctl_wr && ioctl_index == 8'd0;
            end else if (!ddram_busy) begin
                wr_pend_exp = 1'b0;
            end
        end
    end

    // Compares returned data on each ack rise
    always @(posedge fixed_50m_clk) begin
        if (reset) begin
            ack_prev = 3'b000;
        end else begin
            got[0] = {48'd0, cpu_data};
            got[1] = vid_data;
            got[2] = snd_data;
            for (int c = 0; c < 3; c++) begin
                if (ack_of(c) && !ack_prev[c]) begin
                    ack_order.push_back(c);
                    if (!exp_valid[c]) begin
                        err_proto++;
                        $display("client %0d ack rose with no read outstanding at %0t", c, $time);
                    end else if (got[c] !== exp_beat[c]) begin
                        err_value++;
                        $display("[FAIL] %0t client %0d got %h, expected %h",
                                 $time, c, got[c], exp_beat[c]);
                    end
                    exp_valid[c] = 1'b0;
                end
            end
            ack_prev = {snd_ack, vid_ack, cpu_ack};
        end
    end

    initial begin
        int         n;
        logic [2:0] done;
        reset          = 1'b1;
        ioctl_download = 1'b0;
        ioctl_wr       = 1'b0;
        ioctl_addr     = '0;
        ioctl_dout     = '0;
        ioctl_index    = '0;
        cpu_req        = 1'b0;
        cpu_addr       = '0;
        vid_req        = 1'b0;
        vid_addr       = '0;
        snd_req        = 1'b0;
        snd_addr       = '0;
        repeat (4) tick();
        reset = 1'b0;
        if ({ddram_rd, ddram_we, ioctl_wait, cpu_ack, vid_ack, snd_ack} !== 6'b000000) begin
            err_value++;
            $display("[FAIL] %0t outputs not low after reset", $time);
        end

        // Download with a video read held off until it ends
        ioctl_download = 1'b1;
        start_read(1, 29'd40, 2'd0);
        tick();
        for (int i = 0; i < 24; i++) begin
            host_write({20'd0, 4'(rand_bits(4)), 2'(rand_bits(2)), 1'b0},
                       16'(rand_bits(16)), 8'd0);
            repeat (rand_bits(1)) tick();
        end
        host_write({20'd0, 4'd0, 2'd1, 1'b0}, 16'hdead, 8'd1);  // Wrong index is dropped
        tick();
        ioctl_download = 1'b0;
        finish_read(1);

        // CPU word reads over every lane of the written area and beat 20
        for (int b = 0; b < 17; b++) begin
            for (int l = 0; l < 4; l++) begin
                do_read(0, b == 16 ? 29'd20 : 29'(b), 2'(l));
            end
        end
        for (int b = 0; b < 16; b++) begin
            do_read(1, 29'(b), 2'd0);
            do_read(2, 29'(b), 2'd0);
        end
        for (int i = 0; i < 4; i++) begin
            do_read(0, 29'(rand_bits(21)), 2'(rand_bits(2)));
            do_read(1, 29'(rand_bits(29)), 2'd0);
            do_read(2, 29'(rand_bits(29)), 2'd0);
        end

        // All three clients in the same cycle
        for (int r = 0; r < 3; r++) begin
            ack_order.delete();
            start_read(0, 29'(rand_bits(21)), 2'(rand_bits(2)));
            start_read(1, 29'(rand_bits(29)), 2'd0);
            start_read(2, 29'(rand_bits(29)), 2'd0);
            done = 3'b000;
            n    = 0;
            while (done != 3'b111) begin
                tick();
                n++;
                for (int c = 0; c < 3; c++) begin
                    if (!done[c] && ack_of(c)) begin
                        set_req(c, 1'b0);
                        done[c] = 1'b1;
                    end
                end
                if (n > 3 * ACK_TIMEOUT) begin
                    timed_out("all three acknowledges");
                end
            end
            n = 0;
            while (cpu_ack || vid_ack || snd_ack) begin
                tick();
                n++;
                if (n > DROP_TIMEOUT) begin
                    timed_out("the acks to fall");
                end
            end
            if (ack_order.size() != 3 || ack_order[0] != 0 || ack_order[1] != 1
                || ack_order[2] != 2) begin
                err_value++;
                $display("[FAIL] %0t acks did not rise in cpu, video, audio order", $time);
            end
        end
        end_run();
    end

endmodule

// File: pgm_mem_top.f
+incdir+rtl
rtl/pgm_mem_pkg.sv
rtl/ddr_rd_if.sv
rtl/ldr_write_latch.sv
rtl/ddr_rd_arbiter.sv
rtl/pgm_mem_top.sv
sim/ddr_model.sv
sim/tb_pgm_mem_top.sv
